// ==== include/hwpe_settings.svh ====
`ifndef HWPE_SETTINGS_SVH
`define HWPE_SETTINGS_SVH

// number of cores that receive the completion event
`define HWPE_N_CORES 8

// width of the configuration bus transaction id
`define HWPE_ID_WIDTH 8

// lane accumulator width, wide enough for 256 full-scale products
`define HWPE_ACC_WIDTH 40

// register byte offsets, decoded on the low address byte
`define HWPE_REG_TRIGGER 8'h00
`define HWPE_REG_STATUS 8'h04
`define HWPE_REG_X_ADDR 8'h08
`define HWPE_REG_W_ADDR 8'h0C
`define HWPE_REG_LEN 8'h10
`define HWPE_REG_RES_ADDR 8'h14

`endif

// ==== source/hwpe_package.sv ====
`default_nettype none

`include "hwpe_settings.svh"

package hwpe_package;

  // one 32-bit memory or register word
  typedef logic [31:0] word_t;

  // signed lane accumulator
  typedef logic signed [`HWPE_ACC_WIDTH-1:0] acc_t;

  // external configuration bus, wen high means a read as on the cluster peripheral bus
  typedef struct packed {
    logic                      req;
    word_t                     add;
    logic                      wen;
    logic [3:0]                be;
    word_t                     wdata;
    logic [`HWPE_ID_WIDTH-1:0] id;
  } cfg_req_t;

  typedef struct packed {
    logic                      gnt;
    word_t                     r_rdata;
    logic                      r_valid;
    logic [`HWPE_ID_WIDTH-1:0] r_id;
  } cfg_rsp_t;

  // the same bus with the field names the engine uses internally
  typedef struct packed {
    logic                      req;
    word_t                     add;
    logic                      wen;
    logic [3:0]                be;
    word_t                     data;
    logic [`HWPE_ID_WIDTH-1:0] id;
  } periph_req_t;

  typedef struct packed {
    logic                      gnt;
    word_t                     r_data;
    logic                      r_valid;
    logic [`HWPE_ID_WIDTH-1:0] r_id;
  } periph_rsp_t;

  // memory master port, wen high is a read and low is a write
  typedef struct packed {
    logic  req;
    word_t add;
    logic  wen;
    word_t data;
  } tcdm_req_t;

  typedef struct packed {
    logic  gnt;
    word_t r_data;
    logic  r_valid;
  } tcdm_rsp_t;

  // job as programmed through the register file, len counts 32-bit words
  typedef struct packed {
    word_t x_addr;
    word_t w_addr;
    word_t len;
    word_t res_addr;
  } job_cfg_t;

  // command to one multiply-accumulate lane
  typedef struct packed {
    logic               clear;
    logic               enable;
    logic signed [15:0] x;
    logic signed [15:0] w;
  } lane_op_t;

endpackage

`default_nettype wire

// ==== source/mac_lane.sv ====
`default_nettype none

module mac_lane
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  hwpe_package::lane_op_t op,
  output hwpe_package::acc_t     acc
);

  // full-precision product of two signed halves
  logic signed [31:0] prod;

  assign prod = $signed(op.x) * $signed(op.w);

  // the cast sign-extends the product to the accumulator width
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      acc <= '0;
    else if (op.clear)
      acc <= '0;
    else if (op.enable)
      acc <= acc + hwpe_package::acc_t'(prod);
  end

  // the controller clears only between jobs and feeds only inside one
  a_op_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    !(op.clear && op.enable));

endmodule

`default_nettype wire

// ==== source/dot_reduce.sv ====
`default_nettype none

module dot_reduce
(
  input  hwpe_package::acc_t  acc_lo,
  input  hwpe_package::acc_t  acc_hi,
  output hwpe_package::word_t result
);

  // one bit wider than a lane so the sum itself cannot wrap
  localparam int SUM_W = $bits(hwpe_package::acc_t) + 1;

  logic signed [SUM_W-1:0] sum;
  logic                    fits;

  // both operands are signed, so they are sign-extended to the sum width
  assign sum = acc_lo + acc_hi;

  // the sum fits in 32 bits when every bit above bit 30 repeats the sign
  assign fits = (sum[SUM_W-1:31] == '0) || (sum[SUM_W-1:31] == '1);

  always_comb
  begin
    if (fits)
      result = sum[31:0];
    else if (sum[SUM_W-1])
      // below the signed 32-bit range
      result = 32'h8000_0000;
    else
      // above the signed 32-bit range
      result = 32'h7fff_ffff;
  end

endmodule

`default_nettype wire

// ==== source/hwpe_ctrl.sv ====
`default_nettype none

`include "hwpe_settings.svh"

module hwpe_ctrl
#(
  parameter int N_CORES = `HWPE_N_CORES
)
(
  input  logic                      clk,
  input  logic                      arst_n,
  input  hwpe_package::periph_req_t periph_req,
  output hwpe_package::periph_rsp_t periph_rsp,
  output hwpe_package::tcdm_req_t   tcdm_req,
  input  hwpe_package::tcdm_rsp_t   tcdm_rsp,
  output hwpe_package::lane_op_t    lane_lo,
  output hwpe_package::lane_op_t    lane_hi,
  input  hwpe_package::word_t       result,
  output logic [N_CORES-1:0][1:0]   evt,
  output logic                      busy
);

  // st_done is the single cycle after the result write grant, where the event fires
  typedef enum logic [2:0] {
    st_idle,
    st_read_x,
    st_read_w,
    st_accum,
    st_write,
    st_done
  } state_t;

  state_t                           state;
  hwpe_package::job_cfg_t           cfg;
  hwpe_package::word_t              cnt;
  hwpe_package::word_t              x_word;
  hwpe_package::word_t              rd_mux;
  hwpe_package::word_t              rsp_data;
  logic                             rsp_valid;
  logic [$bits(periph_req.id)-1:0]  rsp_id;
  logic [7:0]                       reg_off;
  logic                             reg_wr;
  logic                             start;

  // only the low address byte selects a register
  assign reg_off = periph_req.add[7:0];
  assign reg_wr  = periph_req.req && !periph_req.wen;
  assign busy    = (state != st_idle) && (state != st_done);
  // a trigger is honoured only between jobs
  assign start   = reg_wr && (reg_off == `HWPE_REG_TRIGGER) && !busy;

  always_comb
  begin
    case (reg_off)
      `HWPE_REG_STATUS:   rd_mux = {31'b0, busy};
      `HWPE_REG_X_ADDR:   rd_mux = cfg.x_addr;
      `HWPE_REG_W_ADDR:   rd_mux = cfg.w_addr;
      `HWPE_REG_LEN:      rd_mux = cfg.len;
      `HWPE_REG_RES_ADDR: rd_mux = cfg.res_addr;
      default:            rd_mux = '0;
    endcase
  end

  // every request is granted at once, the response follows one cycle later
  always_comb
  begin
    periph_rsp.gnt     = periph_req.req;
    periph_rsp.r_data  = rsp_data;
    periph_rsp.r_valid = rsp_valid;
    periph_rsp.r_id    = rsp_id;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cfg       <= '0;
      rsp_valid <= 1'b0;
      rsp_id    <= '0;
      rsp_data  <= '0;
    end
    else
    begin
      rsp_valid <= periph_req.req;
      rsp_id    <= periph_req.id;
      // write responses carry no data
      rsp_data  <= periph_req.wen ? rd_mux : '0;
      // the job registers are frozen while a job runs
      if (reg_wr && !busy)
      begin
        case (reg_off)
          `HWPE_REG_X_ADDR:   cfg.x_addr   <= periph_req.data;
          `HWPE_REG_W_ADDR:   cfg.w_addr   <= periph_req.data;
          `HWPE_REG_LEN:      cfg.len      <= periph_req.data;
          `HWPE_REG_RES_ADDR: cfg.res_addr <= periph_req.data;
          default:            cfg          <= cfg;
        endcase
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= st_idle;
      cnt   <= '0;
    end
    else
    begin
      case (state)
        st_idle, st_done:
        begin
          cnt <= '0;
          // a zero length job goes straight to writing the cleared sum
          if (start)
            state <= (cfg.len == '0) ? st_write : st_read_x;
          else
            state <= st_idle;
        end
        st_read_x:
          if (tcdm_rsp.gnt)
            state <= st_read_w;
        st_read_w:
          if (tcdm_rsp.gnt)
            state <= st_accum;
        st_accum:
          if (tcdm_rsp.r_valid)
          begin
            cnt   <= cnt + 32'd1;
            state <= (cnt + 32'd1 == cfg.len) ? st_write : st_read_x;
          end
        st_write:
          if (tcdm_rsp.gnt)
            state <= st_done;
        default:
          state <= st_idle;
      endcase
    end
  end

  // the x data returns in the first st_read_w cycle, one cycle after its grant
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      x_word <= '0;
    else if (state == st_read_w && tcdm_rsp.r_valid)
      x_word <= tcdm_rsp.r_data;
  end

  // fields depend only on state and job registers, so they hold until the grant
  always_comb
  begin
    tcdm_req.req  = 1'b0;
    tcdm_req.add  = '0;
    tcdm_req.wen  = 1'b1;
    tcdm_req.data = '0;
    case (state)
      st_read_x:
      begin
        tcdm_req.req = 1'b1;
        tcdm_req.add = cfg.x_addr + {cnt[29:0], 2'b00};
      end
      st_read_w:
      begin
        tcdm_req.req = 1'b1;
        tcdm_req.add = cfg.w_addr + {cnt[29:0], 2'b00};
      end
      st_write:
      begin
        // the last lane update landed before this state was entered
        tcdm_req.req  = 1'b1;
        tcdm_req.add  = cfg.res_addr;
        tcdm_req.wen  = 1'b0;
        tcdm_req.data = result;
      end
      default:
        tcdm_req.req = 1'b0;
    endcase
  end

  // lanes are cleared on the trigger and fed when the w word arrives
  always_comb
  begin
    lane_lo.clear  = start;
    lane_lo.enable = (state == st_accum) && tcdm_rsp.r_valid;
    lane_lo.x      = x_word[15:0];
    lane_lo.w      = tcdm_rsp.r_data[15:0];
    lane_hi.clear  = start;
    lane_hi.enable = (state == st_accum) && tcdm_rsp.r_valid;
    lane_hi.x      = x_word[31:16];
    lane_hi.w      = tcdm_rsp.r_data[31:16];
  end

  // only bit 0 of each core is used for the completion event
  always_comb
  begin
    for (int i = 0; i < N_CORES; i++)
      evt[i] = {1'b0, state == st_done};
  end

  a_tcdm_stable: assert property (@(posedge clk) disable iff (!arst_n)
    tcdm_req.req && !tcdm_rsp.gnt |=> $stable(tcdm_req));

  a_evt_after_busy: assert property (@(posedge clk) disable iff (!arst_n)
    (|evt) |-> $past(busy));

endmodule

`default_nettype wire

// ==== source/hwpe_subsystem.sv ====
`default_nettype none

`include "hwpe_settings.svh"

module hwpe_subsystem
#(
  parameter int N_CORES = `HWPE_N_CORES
)
(
  input  logic                      clk,
  input  logic                      arst_n,
  input  hwpe_package::cfg_req_t    cfg_req,
  output hwpe_package::cfg_rsp_t    cfg_rsp,
  output hwpe_package::tcdm_req_t   tcdm_req,
  input  hwpe_package::tcdm_rsp_t   tcdm_rsp,
  output logic [N_CORES-1:0][1:0]   evt,
  output logic                      busy
);

  hwpe_package::periph_req_t periph_req;
  hwpe_package::periph_rsp_t periph_rsp;
  hwpe_package::lane_op_t    lane_lo;
  hwpe_package::lane_op_t    lane_hi;
  hwpe_package::acc_t        acc_lo;
  hwpe_package::acc_t        acc_hi;
  hwpe_package::word_t       result;

  // field renaming between the cluster bus and the engine's peripheral port
  always_comb
  begin
    periph_req.req  = cfg_req.req;
    periph_req.add  = cfg_req.add;
    periph_req.wen  = cfg_req.wen;
    periph_req.be   = cfg_req.be;
    periph_req.data = cfg_req.wdata;
    periph_req.id   = cfg_req.id;
  end

  always_comb
  begin
    cfg_rsp.gnt     = periph_rsp.gnt;
    cfg_rsp.r_rdata = periph_rsp.r_data;
    cfg_rsp.r_valid = periph_rsp.r_valid;
    cfg_rsp.r_id    = periph_rsp.r_id;
  end

  hwpe_ctrl #(
    .N_CORES    ( N_CORES    )
  ) u_ctrl (
    .clk        ( clk        ),
    .arst_n     ( arst_n     ),
    .periph_req ( periph_req ),
    .periph_rsp ( periph_rsp ),
    .tcdm_req   ( tcdm_req   ),
    .tcdm_rsp   ( tcdm_rsp   ),
    .lane_lo    ( lane_lo    ),
    .lane_hi    ( lane_hi    ),
    .result     ( result     ),
    .evt        ( evt        ),
    .busy       ( busy       )
  );

  // low lane takes bits 15:0 of each word, high lane bits 31:16
  mac_lane u_lane_lo (
    .clk    ( clk     ),
    .arst_n ( arst_n  ),
    .op     ( lane_lo ),
    .acc    ( acc_lo  )
  );

  mac_lane u_lane_hi (
    .clk    ( clk     ),
    .arst_n ( arst_n  ),
    .op     ( lane_hi ),
    .acc    ( acc_hi  )
  );

  dot_reduce u_reduce (
    .acc_lo ( acc_lo ),
    .acc_hi ( acc_hi ),
    .result ( result )
  );

endmodule

`default_nettype wire

// ==== verif/tcdm_mem_model.sv ====
`default_nettype none

module tcdm_mem_model
#(
  parameter int WORDS = 1024
)
(
  input  logic                    clk,
  input  logic                    arst_n,
  input  hwpe_package::tcdm_req_t tcdm_req,
  output hwpe_package::tcdm_rsp_t tcdm_rsp,
  // backdoor port for preloading words, req high writes data at add
  input  hwpe_package::tcdm_req_t fill
);

  localparam int AW = $clog2(WORDS);

  hwpe_package::word_t mem [WORDS];
  hwpe_package::word_t r_data;
  logic                r_valid;
  // cycles left before the pending or next request is granted
  logic [1:0]          wait_left;

  always_comb
  begin
    tcdm_rsp.gnt     = tcdm_req.req && (wait_left == 2'd0);
    tcdm_rsp.r_valid = r_valid;
    tcdm_rsp.r_data  = r_data;
  end

  always @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wait_left <= 2'd0;
      r_valid   <= 1'b0;
    end
    else
    begin
      // read data is valid exactly one cycle after a granted read
      r_valid <= tcdm_rsp.gnt && tcdm_req.wen;
      if (tcdm_rsp.gnt)
        wait_left <= 2'($urandom_range(3, 0));
      else if (tcdm_req.req)
        wait_left <= wait_left - 2'd1;
    end
  end

  // word addressed, the two low address bits are ignored
  always @(posedge clk)
  begin
    if (tcdm_rsp.gnt && tcdm_req.wen)
      r_data <= mem[tcdm_req.add[AW+1:2]];
    if (tcdm_rsp.gnt && !tcdm_req.wen)
      mem[tcdm_req.add[AW+1:2]] <= tcdm_req.data;
    if (fill.req)
      mem[fill.add[AW+1:2]] <= fill.data;
  end

endmodule

`default_nettype wire

// ==== verif/tb_hwpe_subsystem.sv ====
`default_nettype none

`include "hwpe_settings.svh"

module tb_hwpe_subsystem;

  localparam int N_JOBS = 5;
  localparam logic [1:0] KIND_RANDOM = 2'd0;
  localparam logic [1:0] KIND_POS_FULL = 2'd1;
  localparam logic [1:0] KIND_NEG_FULL = 2'd2;
  // bit 0 of every core set, the shape of one completion event
  localparam logic [`HWPE_N_CORES-1:0][1:0] EVT_PULSE = {`HWPE_N_CORES{2'b01}};

  // poke marks the job that gets register writes and a trigger while busy
  typedef struct packed {
    hwpe_package::word_t x_addr;
    hwpe_package::word_t w_addr;
    hwpe_package::word_t len;
    hwpe_package::word_t res_addr;
    logic [1:0]          kind;
    logic                poke;
  } job_entry_t;

  job_entry_t jobs [N_JOBS] = '{
    '{32'h000, 32'h100, 32'd16, 32'h200, KIND_RANDOM, 1'b0},
    '{32'h040, 32'h140, 32'd8, 32'h204, KIND_POS_FULL, 1'b0},
    '{32'h080, 32'h180, 32'd8, 32'h208, KIND_NEG_FULL, 1'b0},
    '{32'h0c0, 32'h1c0, 32'd0, 32'h20c, KIND_RANDOM, 1'b0},
    '{32'h300, 32'h380, 32'd12, 32'h210, KIND_RANDOM, 1'b1}
  };

  logic                          clk;
  logic                          arst_n;
  hwpe_package::cfg_req_t        cfg_req;
  hwpe_package::cfg_rsp_t        cfg_rsp;
  hwpe_package::tcdm_req_t       tcdm_req;
  hwpe_package::tcdm_rsp_t       tcdm_rsp;
  hwpe_package::tcdm_req_t       fill;
  logic [`HWPE_N_CORES-1:0][1:0] evt;
  logic                          busy;
  logic [`HWPE_ID_WIDTH-1:0]     next_id;
  int                            evt_count = 0;

  hwpe_subsystem u_dut (
    .clk      ( clk      ),
    .arst_n   ( arst_n   ),
    .cfg_req  ( cfg_req  ),
    .cfg_rsp  ( cfg_rsp  ),
    .tcdm_req ( tcdm_req ),
    .tcdm_rsp ( tcdm_rsp ),
    .evt      ( evt      ),
    .busy     ( busy     )
  );

  tcdm_mem_model u_mem (
    .clk      ( clk      ),
    .arst_n   ( arst_n   ),
    .tcdm_req ( tcdm_req ),
    .tcdm_rsp ( tcdm_rsp ),
    .fill     ( fill     )
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string msg);
    stop_run($sformatf("[FAIL] %0t %s", $time, msg));
  endtask

  task automatic check_word(input hwpe_package::word_t got, input hwpe_package::word_t exp,
                            input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s: got %08h, expected %08h", what, got, exp));
  endtask

  // write responses carry no defined data, so with_data is low for them
  task automatic check_rsp(input hwpe_package::cfg_rsp_t got,
                           input hwpe_package::periph_rsp_t exp, input bit with_data,
                           input string what);
    if (got.gnt !== exp.gnt || got.r_valid !== exp.r_valid || got.r_id !== exp.r_id ||
        (with_data && got.r_rdata !== exp.r_data))
      report_mismatch($sformatf(
        "%s: got gnt %b valid %b id %02h data %08h, expected %b %b %02h %08h",
        what, got.gnt, got.r_valid, got.r_id, got.r_rdata,
        exp.gnt, exp.r_valid, exp.r_id, exp.r_data));
  endtask

  task automatic check_evt(input logic [`HWPE_N_CORES-1:0][1:0] got,
                           input logic [`HWPE_N_CORES-1:0][1:0] exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s: got evt %h, expected %h", what, got, exp));
  endtask

  // every event is sampled mid-cycle and counted, so a stuck or doubled pulse shows
  always @(negedge clk)
  begin
    if (evt != '0)
    begin
      check_evt(evt, EVT_PULSE, "completion event shape");
      check_word({31'b0, busy}, 32'h0, "busy while the event is high");
      evt_count <= evt_count + 1;
    end
  end

  // called on a falling edge, the request is granted in its own cycle and the
  // response is taken on the next falling edge
  task automatic cfg_access(input logic rd, input hwpe_package::word_t addr,
                            input hwpe_package::word_t wdata,
                            output hwpe_package::cfg_rsp_t rsp,
                            output logic [`HWPE_ID_WIDTH-1:0] id);
    id = next_id;
    next_id++;
    cfg_req.req = 1'b1;
    cfg_req.add = addr;
    cfg_req.wen = rd;
    cfg_req.be = 4'hf;
    cfg_req.wdata = wdata;
    cfg_req.id = id;
    @(negedge clk);
    // gnt still answers the held request and r_valid belongs to the accepted one
    rsp = cfg_rsp;
    cfg_req.req = 1'b0;
  endtask

  task automatic cfg_write(input logic [7:0] off, input hwpe_package::word_t data);
    hwpe_package::cfg_rsp_t    rsp;
    logic [`HWPE_ID_WIDTH-1:0] id;
    cfg_access(1'b0, {24'h0, off}, data, rsp, id);
    check_rsp(rsp, '{gnt: 1'b1, r_data: '0, r_valid: 1'b1, r_id: id}, 1'b0, "write response");
  endtask

  task automatic cfg_read(input logic [7:0] off, input hwpe_package::word_t exp,
                          input string what);
    hwpe_package::cfg_rsp_t    rsp;
    logic [`HWPE_ID_WIDTH-1:0] id;
    cfg_access(1'b1, {24'h0, off}, 32'h0, rsp, id);
    check_rsp(rsp, '{gnt: 1'b1, r_data: exp, r_valid: 1'b1, r_id: id}, 1'b1, what);
  endtask

  task automatic preload_word(input hwpe_package::word_t addr, input hwpe_package::word_t data);
    fill.req = 1'b1;
    fill.add = addr;
    fill.wen = 1'b0;
    fill.data = data;
    @(negedge clk);
    fill.req = 1'b0;
  endtask

  // both signed halves multiplied pairwise, low with low and high with high
  function automatic longint word_products(input hwpe_package::word_t x,
                                           input hwpe_package::word_t w);
    longint lo;
    longint hi;
    lo = longint'($signed(x[15:0])) * longint'($signed(w[15:0]));
    hi = longint'($signed(x[31:16])) * longint'($signed(w[31:16]));
    return lo + hi;
  endfunction

  function automatic hwpe_package::word_t saturate(input longint sum);
    if (sum > 64'sd2147483647)
      return 32'h7fff_ffff;
    else if (sum < -64'sd2147483648)
      return 32'h8000_0000;
    return sum[31:0];
  endfunction

  task automatic run_job(input job_entry_t j);
    longint              sum;
    hwpe_package::word_t x;
    hwpe_package::word_t w;
    int                  count_before;
    sum = 0;
    for (int i = 0; i < int'(j.len); i++)
    begin
      case (j.kind)
        KIND_POS_FULL:
        begin
          x = 32'h7fff_7fff;
          w = 32'h7fff_7fff;
        end
        KIND_NEG_FULL:
        begin
          x = 32'h8000_8000;
          w = 32'h7fff_7fff;
        end
        default:
        begin
          x = $urandom;
          w = $urandom;
        end
      endcase
      preload_word(j.x_addr + hwpe_package::word_t'(4 * i), x);
      preload_word(j.w_addr + hwpe_package::word_t'(4 * i), w);
      sum += word_products(x, w);
    end
    // a marker at the result address shows a write that never happened
    preload_word(j.res_addr, ~j.res_addr);
    cfg_write(`HWPE_REG_X_ADDR, j.x_addr);
    cfg_write(`HWPE_REG_W_ADDR, j.w_addr);
    cfg_write(`HWPE_REG_LEN, j.len);
    cfg_write(`HWPE_REG_RES_ADDR, j.res_addr);
    cfg_read(`HWPE_REG_X_ADDR, j.x_addr, "x address readback");
    cfg_read(`HWPE_REG_W_ADDR, j.w_addr, "w address readback");
    cfg_read(`HWPE_REG_LEN, j.len, "length readback");
    cfg_read(`HWPE_REG_RES_ADDR, j.res_addr, "result address readback");
    count_before = evt_count;
    cfg_write(`HWPE_REG_TRIGGER, 32'h1);
    check_word({31'b0, busy}, 32'h1, "busy one cycle after the trigger");
    if (j.poke)
    begin
      cfg_read(`HWPE_REG_STATUS, 32'h1, "status while busy");
      cfg_write(`HWPE_REG_X_ADDR, 32'h3f0);
      cfg_write(`HWPE_REG_TRIGGER, 32'h1);
    end
    // the watchdog bounds this wait
    while (evt_count == count_before)
      @(negedge clk);
    check_word(u_mem.mem[j.res_addr[11:2]], saturate(sum), "dot product result");
    check_word({31'b0, busy}, 32'h0, "busy after the event");
    repeat (3) @(negedge clk);
    check_word(hwpe_package::word_t'(evt_count), hwpe_package::word_t'(count_before + 1),
               "event pulses per job");
    check_evt(evt, '0, "event low between jobs");
    cfg_read(`HWPE_REG_X_ADDR, j.x_addr, "x address after the job");
  endtask

  // the whole run is bounded by the total length of the job table
  initial
  begin
    int words;
    words = 0;
    for (int j = 0; j < N_JOBS; j++)
      words += int'(jobs[j].len);
    repeat (200 + 20 * words) @(posedge clk);
    stop_run("the job never completed before the watchdog expired");
  end

  initial
  begin
    void'($urandom(32'h11f4_e1ef));
    arst_n = 1'b0;
    cfg_req = '0;
    fill = '0;
    next_id = '0;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    // idle outputs and cleared registers straight after reset
    check_word({31'b0, busy}, 32'h0, "busy after reset");
    check_evt(evt, '0, "event after reset");
    check_word({31'b0, tcdm_req.req}, 32'h0, "memory request after reset");
    check_word({31'b0, cfg_rsp.r_valid}, 32'h0, "configuration response after reset");
    cfg_read(`HWPE_REG_STATUS, 32'h0, "status after reset");
    cfg_read(`HWPE_REG_X_ADDR, 32'h0, "x address after reset");
    cfg_read(`HWPE_REG_W_ADDR, 32'h0, "w address after reset");
    cfg_read(`HWPE_REG_LEN, 32'h0, "length after reset");
    cfg_read(`HWPE_REG_RES_ADDR, 32'h0, "result address after reset");
    for (int j = 0; j < N_JOBS; j++)
      run_job(jobs[j]);
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
source/hwpe_package.sv
source/mac_lane.sv
source/dot_reduce.sv
source/hwpe_ctrl.sv
source/hwpe_subsystem.sv
verif/tcdm_mem_model.sv
verif/tb_hwpe_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the hwpe_subsystem testbench with Verilator.
# The exit status is 0 only when the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f tb.f --top-module tb_hwpe_subsystem -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "all tests passed"; then
  exit 0
fi
echo "pass message not found in the simulation output"
exit 1
